// ==== project.f ====
+incdir+verilog
+incdir+testbench
verilog/nnPkg.sv
verilog/featureIngress.sv
verilog/neuronNode.sv
verilog/denseLayer.sv
verilog/argmaxStage.sv
verilog/classifierTop.sv
testbench/classifierTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = classifierTb
FILELIST = project.f
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# A missing pass line also counts as a failure, for runs that stop early.
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/classifierModel.svh ====
`ifndef CLASSIFIER_MODEL_SVH
`define CLASSIFIER_MODEL_SVH

// Weight table of neuron n, input 0 in element 0.
function automatic featureVec neuronWeights(input int n);
	case (n)
		0: return `NN_WEIGHTS_0;
		1: return `NN_WEIGHTS_1;
		2: return `NN_WEIGHTS_2;
		3: return `NN_WEIGHTS_3;
		default: return '0;
	endcase
endfunction

function automatic actByte neuronBias(input int n);
	case (n)
		0: return `NN_BIAS_0;
		1: return `NN_BIAS_1;
		2: return `NN_BIAS_2;
		3: return `NN_BIAS_3;
		default: return '0;
	endcase
endfunction

// Exact products and sum, then the low byte and a ReLU on its sign.
function automatic reluByte neuronOutput(input featureVec x, input int n);
	featureVec w;
	int acc;
	logic [7:0] low;
	w = neuronWeights(n);
	acc = int'(neuronBias(n));
	for (int i = 0; i < `NN_INPUTS; i++)
		acc += int'(x[i]) * int'(w[i]);
	// Low byte of the exact sum equals the sum of wrapped products.
	low = acc[7:0];
	if (low[7])
		return '0;
	return low;
endfunction

// Largest score wins, the lower index keeps a tie.
function automatic classResult classifyVector(input featureVec x);
	classResult best;
	reluByte score;
	best.index = '0;
	best.score = neuronOutput(x, 0);
	for (int n = 1; n < `NN_NEURONS; n++)
	begin
		score = neuronOutput(x, n);
		if (score > best.score)
		begin
			best.index = classIndex'(n);
			best.score = score;
		end
	end
	return best;
endfunction

`endif

// ==== testbench/classifierTb.sv ====
`timescale 1ns/1ps
`include "nn_cfg.svh"

module classifierTb import nnPkg::*;
();

	`include "classifierModel.svh"

	localparam int WaitLimit = 200;
	localparam int DrainLimit = 600;
	localparam int Latency = 5;

	logic clk = 1'b0;
	logic reset;
	logic featureValid;
	featureVec features;
	logic featureCredit;
	logic resultValid;
	classResult result;
	logic resultCredit = 1'b0;

	int seed = 32'hef2;
	int cycle = 0;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int senderCredits = `NN_IN_CREDITS;
	int unreturned = 0;
	int creditDelay = 1;
	int sentCount = 0;
	int resultsSeen = 0;
	int lastBeatCycle = 0;
	int lastResultCycle = 0;
	classResult expQ[$];
	int creditDue[$];

	classifierTop i_classifierTop (
		.clk(clk),
		.reset(reset),
		.featureValid(featureValid),
		.features(features),
		.featureCredit(featureCredit),
		.resultValid(resultValid),
		.result(result),
		.resultCredit(resultCredit)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	// Consumer returns one credit per result once it is due.
	// The pulse is set up on the edge before its due cycle.
	always @(posedge clk)
	begin
		if (creditDue.size() != 0 && creditDue[0] <= cycle + 1)
		begin
			resultCredit <= 1'b1;
			void'(creditDue.pop_front());
		end
		else
			resultCredit <= 1'b0;
	end

	function automatic classResult makeResult(input int index, input int score);
		classResult r;
		r.index = classIndex'(index);
		r.score = reluByte'(score);
		return r;
	endfunction

	function automatic featureVec randomVector();
		featureVec v;
		for (int i = 0; i < `NN_INPUTS; i++)
			v[i] = actByte'($random(seed));
		return v;
	endfunction

	function automatic void compareResult(input classResult got);
		classResult exp;
		resultsSeen++;
		assert (expQ.size() != 0)
		else
		begin
			$display("Result index %h score %h arrived with nothing expected.",
				got.index, got.score);
			errorCount++;
		end
		if (expQ.size() != 0)
		begin
			exp = expQ.pop_front();
			assert (got.index == exp.index)
			else
			begin
				$display("MISMATCH result.index: got %h, expected %h", got.index, exp.index);
				errorCount++;
			end
			assert (got.score == exp.score)
			else
			begin
				$display("MISMATCH result.score: got %h, expected %h", got.score, exp.score);
				errorCount++;
			end
		end
	endfunction

	// Outputs are sampled half a cycle after the edge that drives them.
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (featureCredit)
				senderCredits++;
			if (resultCredit)
				unreturned--;
			if (featureValid)
				lastBeatCycle = cycle;
			if (resultValid)
			begin
				compareResult(result);
				lastResultCycle = cycle;
				unreturned++;
				creditDue.push_back(cycle + creditDelay);
			end
			assert (unreturned <= `NN_OUT_CREDITS)
			else
			begin
				$display("%0d results outstanding, more than the %0d output credits.",
					unreturned, `NN_OUT_CREDITS);
				errorCount++;
			end
		end
	end

	task automatic sendVector(input featureVec v, input classResult expected);
		int waited;
		waited = 0;
		@(posedge clk);
		while (senderCredits == 0 && waited < WaitLimit)
		begin
			featureValid <= 1'b0;
			@(posedge clk);
			waited++;
		end
		assert (senderCredits != 0)
		else
		begin
			$display("Timed out waiting for an input credit.");
			errorCount++;
		end
		if (senderCredits != 0)
		begin
			featureValid <= 1'b1;
			features <= v;
			senderCredits--;
			sentCount++;
			expQ.push_back(expected);
		end
		else
			featureValid <= 1'b0;
	endtask

	task automatic idleLink();
		@(posedge clk);
		featureValid <= 1'b0;
	endtask

	// Waits for every result and credit, then checks the accounting.
	task automatic drainPipeline();
		int waited;
		waited = 0;
		idleLink();
		while ((expQ.size() != 0 || unreturned != 0) && waited < DrainLimit)
		begin
			@(posedge clk);
			waited++;
		end
		assert (expQ.size() == 0 && unreturned == 0)
		else
		begin
			$display("Timed out with %0d results missing and %0d output credits unreturned.",
				expQ.size(), unreturned);
			errorCount++;
		end
		assert (resultsSeen == sentCount)
		else
		begin
			$display("%0d results arrived for %0d vectors sent.", resultsSeen, sentCount);
			errorCount++;
		end
		assert (senderCredits == `NN_IN_CREDITS)
		else
		begin
			$display("Sender holds %0d input credits instead of %0d.",
				senderCredits, `NN_IN_CREDITS);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsAtStart);
		testsRun++;
		if (errorCount == errorsAtStart)
			$display("%s: ok", name);
		else
		begin
			testsFailed++;
			$display("%s: %0d errors", name, errorCount - errorsAtStart);
		end
	endtask

	task automatic referenceNeuronTest();
		int errorsAtStart;
		featureVec v;
		errorsAtStart = errorCount;
		// Input 12 carries neuron 0's weight 0x4F.
		v = '0;
		v[12] = 8'sd1;
		sendVector(v, makeResult(0, 8'h4E));
		// 315 wraps to 0x3B.
		v[12] = 8'sd4;
		sendVector(v, makeResult(0, 8'h3B));
		// Neuron 0 goes negative and clamps.
		v[12] = -8'sd1;
		sendVector(v, makeResult(1, 8'h21));
		drainPipeline();
		reportTest("reference neuron", errorsAtStart);
	endtask

	task automatic tieAndZeroTest();
		int errorsAtStart;
		featureVec v;
		errorsAtStart = errorCount;
		// All four sums negative.
		v = '0;
		v[9] = 8'sd1;
		v[14] = 8'sd2;
		v[5] = -8'sd1;
		sendVector(v, makeResult(0, 8'h00));
		// Neurons 2 and 3 both reach 0x10.
		v = '0;
		v[12] = 8'sd2;
		sendVector(v, makeResult(2, 8'h10));
		drainPipeline();
		reportTest("ties and all-zero", errorsAtStart);
	endtask

	task automatic latencyTest();
		int errorsAtStart;
		featureVec v;
		errorsAtStart = errorCount;
		v = randomVector();
		sendVector(v, classifyVector(v));
		drainPipeline();
		assert (lastResultCycle - lastBeatCycle == Latency)
		else
		begin
			$display("MISMATCH resultValid latency: got %h, expected %h",
				lastResultCycle - lastBeatCycle, Latency);
			errorCount++;
		end
		reportTest("unobstructed latency", errorsAtStart);
	endtask

	task automatic streamingTest();
		int errorsAtStart;
		featureVec v;
		errorsAtStart = errorCount;
		repeat (20)
		begin
			v = randomVector();
			sendVector(v, classifyVector(v));
		end
		drainPipeline();
		reportTest("streaming order", errorsAtStart);
	endtask

	task automatic backPressureTest();
		int errorsAtStart;
		featureVec v;
		errorsAtStart = errorCount;
		creditDelay = 20;
		repeat (8)
		begin
			v = randomVector();
			sendVector(v, classifyVector(v));
		end
		drainPipeline();
		creditDelay = 1;
		reportTest("output back-pressure", errorsAtStart);
	endtask

	initial
	begin
		reset = 1'b1;
		featureValid = 1'b0;
		features = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		referenceNeuronTest();
		tieAndZeroTest();
		latencyTest();
		streamingTest();
		backPressureTest();
		$display("Tests run %0d, tests failed %0d, checks failed %0d.",
			testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog/classifierTop.sv ====
`timescale 1ns/1ps

module classifierTop import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic featureValid,
	input featureVec features,
	output logic featureCredit,
	output logic resultValid,
	output classResult result,
	input logic resultCredit
);

	logic launchValid;
	featureVec launchVec;
	logic actValid;
	activationVec acts;

	featureIngress i_featureIngress (
		.clk(clk),
		.reset(reset),
		.featureValid(featureValid),
		.features(features),
		.featureCredit(featureCredit),
		.resultCredit(resultCredit),
		.launchValid(launchValid),
		.launchVec(launchVec)
	);

	denseLayer i_denseLayer (
		.clk(clk),
		.reset(reset),
		.launchValid(launchValid),
		.launchVec(launchVec),
		.actValid(actValid),
		.acts(acts)
	);

	argmaxStage i_argmaxStage (
		.clk(clk),
		.reset(reset),
		.actValid(actValid),
		.acts(acts),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

// ==== verilog/argmaxStage.sv ====
`timescale 1ns/1ps
`include "nn_cfg.svh"

module argmaxStage import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic actValid,
	input activationVec acts,
	output logic resultValid,
	output classResult result
);

	classIndex bestIdx;
	reluByte bestScore;

	// The strict compare leaves a tie with the lower index.
	always_comb
	begin
		bestIdx = '0;
		bestScore = acts[0];
		for (int n = 1; n < `NN_NEURONS; n++)
		begin
			if (acts[n] > bestScore)
			begin
				bestIdx = classIndex'(n);
				bestScore = acts[n];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		result.index <= bestIdx;
		result.score <= bestScore;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= actValid;
	end

	// Score is the largest activation and no lower index reaches it.
	for (genvar n = 0; n < `NN_NEURONS; n++)
	begin : g_check
		assert property (@(posedge clk) disable iff (reset)
			resultValid |-> $past(acts[n]) <= result.score
				&& (result.index != classIndex'(n) || $past(acts[n]) == result.score)
				&& (result.index <= classIndex'(n) || $past(acts[n]) < result.score))
			else $error("argmaxStage: result is not the first largest activation.");
	end

endmodule

// ==== verilog/denseLayer.sv ====
`timescale 1ns/1ps
`include "nn_cfg.svh"

module denseLayer import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic launchValid,
	input featureVec launchVec,
	output logic actValid,
	output activationVec acts
);

	localparam int Depth = 3;

	localparam featureVec WeightTable [`NN_NEURONS] = '{
		`NN_WEIGHTS_0,
		`NN_WEIGHTS_1,
		`NN_WEIGHTS_2,
		`NN_WEIGHTS_3
	};

	localparam actByte BiasTable [`NN_NEURONS] = '{
		`NN_BIAS_0,
		`NN_BIAS_1,
		`NN_BIAS_2,
		`NN_BIAS_3
	};

	logic [Depth-1:0] validPipe;

	for (genvar n = 0; n < `NN_NEURONS; n++)
	begin : g_neuron
		neuronNode #(
			.weights(WeightTable[n]),
			.bias(BiasTable[n])
		) i_neuronNode (
			.clk(clk),
			.reset(reset),
			.acts(launchVec),
			.activation(acts[n])
		);
	end

	// Tracks vectors through input, sum and ReLU registers.
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[Depth-2:0], launchValid};
	end

	assign actValid = validPipe[Depth-1];

endmodule

// ==== verilog/neuronNode.sv ====
`timescale 1ns/1ps
`include "nn_cfg.svh"

module neuronNode import nnPkg::*;
#(
	parameter featureVec weights = `NN_WEIGHTS_0,
	parameter actByte bias = `NN_BIAS_0
)
(
	input logic clk,
	input logic reset,
	input featureVec acts,
	output logic [`NN_WIDTH-1:0] activation
);

	featureVec actsReg;
	actByte macSum;
	actByte sumReg;

	// Products keep their low byte, the sum wraps modulo 256.
	always_comb
	begin
		macSum = bias;
		for (int i = 0; i < `NN_INPUTS; i++)
			macSum = macSum + actByte'(actsReg[i] * weights[i]);
	end

	// Input capture.
	always_ff @(posedge clk)
	begin
		actsReg <= acts;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			sumReg <= macSum;
			// ReLU on the sign bit.
			if (sumReg[`NN_WIDTH-1])
				activation <= '0;
			else
				activation <= sumReg;
		end
	end

endmodule

// ==== verilog/featureIngress.sv ====
`timescale 1ns/1ps
`include "nn_cfg.svh"

module featureIngress import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic featureValid,
	input featureVec features,
	output logic featureCredit,
	input logic resultCredit,
	output logic launchValid,
	output featureVec launchVec
);

	localparam int Depth = `NN_IN_CREDITS;
	localparam int PtrW = $clog2(Depth);
	localparam int CountW = $clog2(Depth + 1);
	// One spare value so an excess credit shows up.
	localparam int OutW = $clog2(`NN_OUT_CREDITS + 2);

	featureVec queueMem [Depth];
	logic [PtrW-1:0] rdPtr;
	logic [PtrW-1:0] wrPtr;
	logic [CountW-1:0] count;
	logic [OutW-1:0] outCredits;

	logic queueEmpty;
	logic queueFull;
	logic haveCredit;
	logic launch;
	logic bypass;
	logic push;
	logic pop;

	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		if (ptr == PtrW'(Depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign queueEmpty = count == '0;
	assign queueFull = count == CountW'(Depth);
	assign haveCredit = outCredits != '0;

	// Launch from the head, or straight from the link when the queue is empty.
	assign launch = haveCredit && (!queueEmpty || featureValid);
	assign bypass = launch && queueEmpty;
	assign pop = launch && !queueEmpty;
	assign push = featureValid && !bypass;

	always_ff @(posedge clk)
	begin
		if (push)
			queueMem[wrPtr] <= features;
		if (launch)
			launchVec <= bypass ? features : queueMem[rdPtr];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			outCredits <= OutW'(`NN_OUT_CREDITS);
			launchValid <= 1'b0;
			featureCredit <= 1'b0;
		end
		else
		begin
			launchValid <= launch;
			// Every launch frees the slot its beat was charged to.
			featureCredit <= launch;
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({launch, resultCredit})
				2'b10: outCredits <= outCredits - 1'b1;
				2'b01: outCredits <= outCredits + 1'b1;
				default: outCredits <= outCredits;
			endcase
		end
	end

	// Sender beat without a credit.
	assert property (@(posedge clk) disable iff (reset) !(push && queueFull))
		else $error("featureIngress: push into a full queue.");

	// Consumer returned more credits than it was given.
	assert property (@(posedge clk) disable iff (reset) outCredits <= OutW'(`NN_OUT_CREDITS))
		else $error("featureIngress: output credits above %0d.", `NN_OUT_CREDITS);

endmodule

// ==== verilog/nnPkg.sv ====
`include "nn_cfg.svh"

package nnPkg;

	// One signed input activation or weight.
	typedef logic signed [`NN_WIDTH-1:0] actByte;

	// One ReLU output, never negative.
	typedef logic [`NN_WIDTH-1:0] reluByte;

	// Element selects stay signed through the named element type.
	typedef actByte [`NN_INPUTS-1:0] featureVec;

	typedef reluByte [`NN_NEURONS-1:0] activationVec;

	typedef logic [$clog2(`NN_NEURONS)-1:0] classIndex;

	// Winning class and its activation.
	typedef struct packed
	{
		classIndex index;
		reluByte score;
	} classResult;

endpackage

// ==== verilog/nn_cfg.svh ====
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// Layer sizes.
`define NN_INPUTS 15
`define NN_NEURONS 4
`define NN_WIDTH 8

// Ingress queue depth, equal to the sender's starting credits.
`define NN_IN_CREDITS 4
// Results the consumer can hold before it returns credits.
`define NN_OUT_CREDITS 2

// Weight tables list input 14 first and input 0 last.
`define NN_WEIGHTS_0 { \
	8'shFB, 8'sh11, 8'sh4F, 8'sh9F, 8'shAE, 8'shF4, 8'sh60, 8'sh1F, \
	8'shFA, 8'shF8, 8'sh66, 8'shBE, 8'sh03, 8'shCF, 8'shD0 }
`define NN_BIAS_0 8'shFF

`define NN_WEIGHTS_1 { \
	8'sh05, 8'sh1A, 8'shE3, 8'sh22, 8'sh07, 8'shC9, 8'sh14, 8'sh3B, \
	8'shF1, 8'sh0C, 8'shD6, 8'sh29, 8'sh44, 8'shEE, 8'sh12 }
`define NN_BIAS_1 8'sh04

`define NN_WEIGHTS_2 { \
	8'shE8, 8'sh31, 8'sh0B, 8'shD2, 8'sh19, 8'sh27, 8'shFE, 8'shC4, \
	8'sh36, 8'sh02, 8'sh1D, 8'shF6, 8'shB8, 8'sh0F, 8'sh2C }
`define NN_BIAS_2 8'shFA

`define NN_WEIGHTS_3 { \
	8'sh13, 8'shDD, 8'sh08, 8'sh3E, 8'shCB, 8'shF3, 8'sh25, 8'sh0A, \
	8'shE1, 8'sh4A, 8'shFC, 8'sh17, 8'shD9, 8'sh2E, 8'shF0 }
`define NN_BIAS_3 8'sh00

`endif
